/* dv/bpu_stim.txt */
# U pc taken target | L pc is_branch exp_hit exp_taken exp_target | F | B | T name
# A base count (taken updates, pc step 4) | K base count exp_hits; pc/target hex
# sweep after reset, lookups miss and updates are lost
L 00001000 1 0 0 00000000
U 00001000 1 00002000
L 00001000 1 0 0 00000000
B
L 00001000 1 0 0 00000000
T reset_sweep
# counter training on one pc
U 00001000 1 00002000
L 00001000 1 1 1 00002000
U 00001000 0 00003000
L 00001000 1 1 0 00002000
U 00001000 1 00002000
U 00001000 1 00002000
U 00001000 1 00002000
U 00001000 0 00003000
U 00001000 0 00003000
L 00001000 1 1 0 00002000
U 00001000 0 00003000
U 00001000 0 00003000
U 00001000 1 00002000
U 00001000 1 00002000
L 00001000 1 1 1 00002000
T counter_training
# target policy, entry allocated by a not-taken update
U 00001040 0 00004444
L 00001040 1 1 0 00004444
U 00001040 0 00005555
L 00001040 1 1 0 00004444
U 00001040 1 00006666
L 00001040 1 1 0 00006666
L 00001040 0 0 0 00000000
T target_policy
# capacity from an empty table, then one replacement
F
B
A 00002000 16
K 00002000 16 16
U 00003000 1 00003100
L 00003000 1 1 1 00003100
K 00002000 16 15
T capacity
# flush empties the table, second pulse lands inside the sweep
U 00001000 1 00002000
L 00001000 1 1 1 00002000
F
U 00004000 1 00004100
F
B
L 00001000 1 0 0 00000000
L 00004000 1 0 0 00000000
T flush

/* vlog.f */
+incdir+dv
src/bpu_cfg_pkg.sv
src/bpu_types_pkg.sv
src/bpu_lfsr_victim.sv
src/bpu_flush_fsm.sv
src/bpu_tag_cam.sv
src/bpu_predictor.sv
src/bpu_top.sv
dv/bpu_tb.sv

/* dv/bpu_tb_checks.svh */
`ifndef BPU_TB_CHECKS_SVH
`define BPU_TB_CHECKS_SVH

// compare tasks, included inside the testbench module body

// prediction fields printed as hit/taken/target
task automatic predict_compare(input string sig, input bpu_predict_t exp,
                               input bpu_predict_t act);
  checks++;
  if (act !== exp) begin
    errors++;
    test_errs++;
    $display("Mismatch at %0t: %s expected %0b/%0b/%h actual %0b/%0b/%h",
             $time, sig, exp.hit, exp.taken, exp.target, act.hit, act.taken, act.target);
  end
endtask

task automatic busy_compare(input string sig, input logic exp, input logic act);
  checks++;
  if (act !== exp) begin
    errors++;
    test_errs++;
    $display("Mismatch at %0t: %s expected %0b actual %0b", $time, sig, exp, act);
  end
endtask

// hit tallies and busy run lengths
task automatic count_compare(input string sig, input int exp, input int act);
  checks++;
  if (act != exp) begin
    errors++;
    test_errs++;
    $display("Mismatch at %0t: %s expected %0d actual %0d", $time, sig, exp, act);
  end
endtask

`endif

/* dv/bpu_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module bpu_tb
  import bpu_cfg_pkg::*;
  import bpu_types_pkg::*;
();

  logic         clk;
  logic         rst;
  logic         flush;
  bpu_lookup_t  lookup;
  bpu_update_t  update;
  bpu_predict_t predict;
  logic         busy;

  int           fd;
  int           n;
  string        line;
  string        cmd;
  string        name;
  logic [31:0]  rng;
  logic [31:0]  pc;
  logic [31:0]  tgt;
  int           arg1;
  int           arg2;
  int           arg3;
  bpu_predict_t exp_pred;
  logic         abort;
  int           errors = 0;
  int           test_errs = 0;
  int           checks = 0;
  int           tests_pass = 0;
  int           tests_fail = 0;
  int           busy_len = 0;
  int           last_busy_len = 0;

  `include "bpu_tb_checks.svh"

  bpu_top UUT (
    .clk       (clk),
    .rst       (rst),
    .flush_i   (flush),
    .lookup_i  (lookup),
    .update_i  (update),
    .predict_o (predict),
    .busy_o    (busy)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // length of the last finished busy run from values seen before the edge
  always @(posedge clk) begin
    if (rst) begin
      busy_len = 0;
    end else if (busy) begin
      busy_len = busy_len + 1;
    end else if (busy_len != 0) begin
      last_busy_len = busy_len;
      busy_len = 0;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic drive_idle();
    @(posedge clk);
    flush  <= 1'b0;
    lookup <= '0;
    update <= '0;
  endtask

  task automatic send_update(input logic [31:0] upc, input logic tk,
                             input logic [31:0] utgt);
    bpu_update_t u;
    u.valid     = 1'b1;
    u.is_branch = 1'b1;
    u.pc        = upc;
    u.taken     = tk;
    u.target    = utgt;
    @(posedge clk);
    flush  <= 1'b0;
    lookup <= '0;
    update <= u;
  endtask

  // predict_o is combinational and settles by mid cycle
  task automatic check_lookup(input logic [31:0] lpc, input logic isb,
                              input bpu_predict_t exp);
    bpu_lookup_t l;
    l.pc        = lpc;
    l.is_branch = isb;
    @(posedge clk);
    flush  <= 1'b0;
    lookup <= l;
    update <= '0;
    @(negedge clk);
    predict_compare("predict_o", exp, predict);
  endtask

  task automatic pulse_flush();
    @(posedge clk);
    flush  <= 1'b1;
    lookup <= '0;
    update <= '0;
  endtask

  task automatic wait_not_busy();
    int cycles;
    cycles = 0;
    while (!abort) begin
      drive_idle();
      @(negedge clk);
      if (!busy) break;
      cycles++;
      if (cycles > 2 * BHT_NUM) begin
        $display("Timeout at %0t: busy_o did not drop within %0d cycles", $time, cycles);
        errors++;
        test_errs++;
        abort = 1'b1;
      end
    end
    if (!abort) begin
      // one more edge so the run length monitor closes the run
      drive_idle();
      @(negedge clk);
      count_compare("busy run length", BHT_NUM, last_busy_len);
    end
  endtask

  // taken updates on consecutive word addresses
  task automatic allocate_range(input logic [31:0] base, input int cnt);
    for (int i = 0; i < cnt; i++) begin
      send_update(base + 32'(i * 4), 1'b1, base + 32'(i * 4) + 32'h100);
    end
  endtask

  task automatic count_hits(input logic [31:0] base, input int cnt, input int exp_hits);
    bpu_lookup_t l;
    int          hits;
    hits = 0;
    for (int i = 0; i < cnt; i++) begin
      l.pc        = base + 32'(i * 4);
      l.is_branch = 1'b1;
      @(posedge clk);
      flush  <= 1'b0;
      lookup <= l;
      update <= '0;
      @(negedge clk);
      if (predict.hit === 1'b1) hits++;
    end
    count_compare("hit count", exp_hits, hits);
  endtask

  task automatic close_test(input string tname);
    if (test_errs == 0) begin
      tests_pass++;
      $display("test %s: pass", tname);
    end else begin
      tests_fail++;
      $display("test %s: FAIL with %0d errors", tname, test_errs);
    end
    test_errs = 0;
  endtask

  initial begin
    rst    = 1'b1;
    flush  = 1'b0;
    lookup = '0;
    update = '0;
    rng    = 32'd87;
    abort  = 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    busy_compare("busy_o", 1'b1, busy);
    fd = $fopen("dv/bpu_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file dv/bpu_stim.txt");
      errors++;
    end else begin
      while (!abort && $fgets(line, fd) != 0) begin
        n = $sscanf(line, "%s", cmd);
        if (n >= 1 && cmd[0] != "#") begin
          rng = xorshift32(rng);
          repeat (rng % 4) drive_idle();
          if (cmd == "U") begin
            n = $sscanf(line, "%s %h %d %h", cmd, pc, arg1, tgt);
            send_update(pc, arg1[0], tgt);
          end else if (cmd == "L") begin
            n = $sscanf(line, "%s %h %d %d %d %h", cmd, pc, arg1, arg2, arg3, tgt);
            exp_pred.hit    = arg2[0];
            exp_pred.taken  = arg3[0];
            exp_pred.target = tgt;
            check_lookup(pc, arg1[0], exp_pred);
          end else if (cmd == "F") begin
            pulse_flush();
          end else if (cmd == "B") begin
            wait_not_busy();
          end else if (cmd == "A") begin
            n = $sscanf(line, "%s %h %d", cmd, pc, arg1);
            allocate_range(pc, arg1);
          end else if (cmd == "K") begin
            n = $sscanf(line, "%s %h %d %d", cmd, pc, arg1, arg2);
            count_hits(pc, arg1, arg2);
          end else if (cmd == "T") begin
            n = $sscanf(line, "%s %s", cmd, name);
            close_test(name);
          end else begin
            $display("Unknown command %s in the stimulus file", cmd);
            errors++;
            test_errs++;
          end
        end
      end
      $fclose(fd);
    end
    $display("Summary: %0d tests passed, %0d tests failed, %0d checks, %0d errors",
             tests_pass, tests_fail, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src/bpu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module bpu_top
  import bpu_types_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic        flush_i,
  input  wire bpu_lookup_t lookup_i,
  input  wire bpu_update_t update_i,
  output bpu_predict_t     predict_o,
  output logic             busy_o
);

  logic     clr;
  bht_idx_t clr_idx;

  // table invalidate sequencer
  bpu_flush_fsm u_flush_fsm (
    .clk       (clk),
    .rst       (rst),
    .flush_i   (flush_i),
    .busy_o    (busy_o),
    .clr_o     (clr),
    .clr_idx_o (clr_idx)
  );

  // lookup, training and the table itself
  bpu_predictor u_predictor (
    .clk       (clk),
    .rst       (rst),
    .lookup_i  (lookup_i),
    .update_i  (update_i),
    .busy_i    (busy_o),
    .clr_i     (clr),
    .clr_idx_i (clr_idx),
    .predict_o (predict_o)
  );

endmodule

`default_nettype wire

/* src/bpu_predictor.sv */
`timescale 1ns/10ps
`default_nettype none

module bpu_predictor
  import bpu_cfg_pkg::*;
  import bpu_types_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire bpu_lookup_t lookup_i,
  input  wire bpu_update_t update_i,
  input  wire logic        busy_i,
  input  wire logic        clr_i,
  input  wire bht_idx_t    clr_idx_i,
  output bpu_predict_t     predict_o
);

  logic            cam_lkp_hit;
  bht_entry_t      cam_lkp_entry;
  logic            cam_upd_hit;
  bht_ctr_t        cam_upd_ctr;
  logic [PC_W-1:0] cam_upd_target;
  logic            lkp_hit;
  logic            upd_accept;
  bht_ctr_t        ctr_next;
  bht_entry_t      wdata;

  bpu_tag_cam u_tag_cam (
    .clk             (clk),
    .rst             (rst),
    .lookup_pc_i     (lookup_i.pc),
    .lookup_hit_o    (cam_lkp_hit),
    .lookup_entry_o  (cam_lkp_entry),
    .update_pc_i     (update_i.pc),
    .update_hit_o    (cam_upd_hit),
    .update_ctr_o    (cam_upd_ctr),
    .update_target_o (cam_upd_target),
    .we_i            (upd_accept),
    .wdata_i         (wdata),
    .clr_i           (clr_i),
    .clr_idx_i       (clr_idx_i)
  );

  // fetch side, nothing hits while the sweep runs
  assign lkp_hit = lookup_i.is_branch && cam_lkp_hit && !busy_i;

  always_comb begin
    predict_o.hit    = lkp_hit;
    predict_o.taken  = lkp_hit && cam_lkp_entry.ctr[1];
    predict_o.target = lkp_hit ? cam_lkp_entry.target : '0;
  end

  // updates during a sweep are simply lost
  assign upd_accept = update_i.valid && update_i.is_branch && !busy_i;

  // saturating counter step, fresh entries start weak
  always_comb begin
    if (!cam_upd_hit) begin
      ctr_next = update_i.taken ? CTR_WT : CTR_WNT;
    end else if (update_i.taken) begin
      ctr_next = (cam_upd_ctr == CTR_ST) ? CTR_ST : cam_upd_ctr + 1'b1;
    end else begin
      ctr_next = (cam_upd_ctr == CTR_SNT) ? CTR_SNT : cam_upd_ctr - 1'b1;
    end
  end

  // not-taken hit keeps the known target
  always_comb begin
    wdata.valid  = 1'b1;
    wdata.tag    = update_i.pc;
    wdata.ctr    = ctr_next;
    wdata.target = (cam_upd_hit && !update_i.taken) ? cam_upd_target : update_i.target;
  end

endmodule

`default_nettype wire

/* src/bpu_tag_cam.sv */
`timescale 1ns/10ps
`default_nettype none

module bpu_tag_cam
  import bpu_cfg_pkg::*;
  import bpu_types_pkg::*;
(
  input  wire logic            clk,
  input  wire logic            rst,
  // fetch side match
  input  wire logic [PC_W-1:0] lookup_pc_i,
  output logic                 lookup_hit_o,
  output bht_entry_t           lookup_entry_o,
  // execute side match
  input  wire logic [PC_W-1:0] update_pc_i,
  output logic                 update_hit_o,
  output bht_ctr_t             update_ctr_o,
  output logic [PC_W-1:0]      update_target_o,
  // entry write
  input  wire logic            we_i,
  input  wire bht_entry_t      wdata_i,
  // sweep invalidate
  input  wire logic            clr_i,
  input  wire bht_idx_t        clr_idx_i
);

  bht_entry_t         bht_q [BHT_NUM];
  logic [BHT_NUM-1:0] lkp_match;
  logic [BHT_NUM-1:0] upd_match;
  logic [BHT_NUM-1:0] entry_free;
  bht_idx_t           lkp_idx;
  bht_idx_t           upd_idx;
  bht_idx_t           free_idx;
  logic               has_free;
  bht_idx_t           victim_idx;
  bht_idx_t           wr_idx;

  bpu_lfsr_victim u_lfsr_victim (
    .clk      (clk),
    .rst      (rst),
    .victim_o (victim_idx)
  );

  // compare both pcs against every tag at once
  always_comb begin
    for (int i = 0; i < BHT_NUM; i++) begin
      lkp_match[i]  = bht_q[i].valid && (bht_q[i].tag == lookup_pc_i);
      upd_match[i]  = bht_q[i].valid && (bht_q[i].tag == update_pc_i);
      entry_free[i] = !bht_q[i].valid;
    end
  end

  // encoders walk down so the lowest free slot wins
  always_comb begin
    lkp_idx  = '0;
    upd_idx  = '0;
    free_idx = '0;
    has_free = 1'b0;
    for (int i = BHT_NUM - 1; i >= 0; i--) begin
      if (lkp_match[i]) begin
        lkp_idx = bht_idx_t'(i);
      end
      if (upd_match[i]) begin
        upd_idx = bht_idx_t'(i);
      end
      if (entry_free[i]) begin
        free_idx = bht_idx_t'(i);
        has_free = 1'b1;
      end
    end
  end

  assign lookup_hit_o   = |lkp_match;
  assign lookup_entry_o = bht_q[lkp_idx];

  assign update_hit_o    = |upd_match;
  assign update_ctr_o    = bht_q[upd_idx].ctr;
  assign update_target_o = bht_q[upd_idx].target;

  // matching slot first, then lowest free, then lfsr victim
  always_comb begin
    if (update_hit_o) begin
      wr_idx = upd_idx;
    end else if (has_free) begin
      wr_idx = free_idx;
    end else begin
      wr_idx = victim_idx;
    end
  end

  // sweep clear wins over a write to the same slot
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < BHT_NUM; i++) begin
        bht_q[i].valid <= 1'b0;
      end
    end else begin
      if (we_i) begin
        bht_q[wr_idx] <= wdata_i;
      end
      if (clr_i) begin
        bht_q[clr_idx_i].valid <= 1'b0;
      end
    end
  end

  // allocation never creates a second copy of a pc
  a_single_match: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(lkp_match) && $onehot0(upd_match)
  ) else $error("pc matches more than one table entry");

endmodule

`default_nettype wire

/* src/bpu_flush_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module bpu_flush_fsm
  import bpu_cfg_pkg::*;
  import bpu_types_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic flush_i,
  output logic      busy_o,
  output logic      clr_o,
  output bht_idx_t  clr_idx_o
);

  typedef enum logic {
    IDLE,
    SWEEP
  } state_t;

  state_t   state_q;
  state_t   state_d;
  bht_idx_t cnt_q;
  bht_idx_t cnt_d;

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      IDLE: begin
        // new sweep always starts from entry 0
        if (flush_i) begin
          state_d = SWEEP;
          cnt_d   = '0;
        end
      end
      SWEEP: begin
        // flush_i has no effect here
        cnt_d = cnt_q + 1'b1;
        if (cnt_q == bht_idx_t'(BHT_NUM - 1)) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // reset itself kicks off a full sweep
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= SWEEP;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  assign busy_o    = (state_q == SWEEP);
  assign clr_o     = (state_q == SWEEP);
  assign clr_idx_o = cnt_q;

  // a flush from idle clears entry 0 first
  a_sweep_from_zero: assert property (
    @(posedge clk) disable iff (rst)
    (!busy_o && flush_i) |=> busy_o && clr_idx_o == '0
  ) else $error("flush from idle did not start the sweep at entry 0");

  // flush during a sweep must not rewind the index
  a_flush_no_restart: assert property (
    @(posedge clk) disable iff (rst)
    (busy_o && flush_i && clr_idx_o != bht_idx_t'(BHT_NUM - 1))
      |=> busy_o && clr_idx_o == bht_idx_t'($past(clr_idx_o) + 1'b1)
  ) else $error("flush while busy restarted the sweep");

endmodule

`default_nettype wire

/* src/bpu_lfsr_victim.sv */
`timescale 1ns/10ps
`default_nettype none

module bpu_lfsr_victim
  import bpu_cfg_pkg::*;
  import bpu_types_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst,
  output bht_idx_t  victim_o
);

  logic [LFSR_W-1:0] lfsr_q;
  logic [LFSR_W-1:0] lfsr_d;

  // galois step: shift right, fold taps in when a one drops out
  always_comb begin
    lfsr_d = {1'b0, lfsr_q[LFSR_W-1:1]};
    if (lfsr_q[0]) begin
      lfsr_d = lfsr_d ^ LFSR_TAPS;
    end
  end

  // free running, also while nothing is allocated
  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr_q <= LFSR_SEED;
    end else begin
      lfsr_q <= lfsr_d;
    end
  end

  // low bits pick the replacement slot
  assign victim_o = lfsr_q[BHT_IDX_W-1:0];

  // all-zero is the lock-up state of this lfsr
  a_lfsr_nonzero: assert property (
    @(posedge clk) disable iff (rst)
    lfsr_q != '0
  ) else $error("victim lfsr locked up in the zero state");

endmodule

`default_nettype wire

/* src/bpu_types_pkg.sv */
`default_nettype none

package bpu_types_pkg;

  import bpu_cfg_pkg::*;

  // saturating direction counter
  typedef logic [1:0] bht_ctr_t;

  // table entry index
  typedef logic [BHT_IDX_W-1:0] bht_idx_t;

  // fetch side request
  typedef struct packed {
    logic [PC_W-1:0] pc;
    logic            is_branch;
  } bpu_lookup_t;

  // fetch side answer
  typedef struct packed {
    logic            hit;
    logic            taken;
    logic [PC_W-1:0] target;
  } bpu_predict_t;

  // execute side report of a resolved instruction
  typedef struct packed {
    logic            valid;
    logic            is_branch;
    logic [PC_W-1:0] pc;
    logic            taken;
    logic [PC_W-1:0] target;
  } bpu_update_t;

  // one table slot, the full pc serves as tag
  typedef struct packed {
    logic            valid;
    logic [PC_W-1:0] tag;
    bht_ctr_t        ctr;
    logic [PC_W-1:0] target;
  } bht_entry_t;

endpackage

`default_nettype wire

/* src/bpu_cfg_pkg.sv */
`default_nettype none

package bpu_cfg_pkg;

  // table geometry
  localparam int BHT_NUM   = 16;
  localparam int BHT_IDX_W = $clog2(BHT_NUM);

  // pc and branch target width
  localparam int PC_W = 32;

  // 2-bit saturating counter states
  // msb of the counter is the taken prediction
  localparam logic [1:0] CTR_SNT = 2'b00;
  localparam logic [1:0] CTR_WNT = 2'b01;
  localparam logic [1:0] CTR_WT  = 2'b10;
  localparam logic [1:0] CTR_ST  = 2'b11;

  // replacement lfsr
  localparam int LFSR_W = 8;

  // must never be zero
  localparam logic [LFSR_W-1:0] LFSR_SEED = 8'hA5;

  // galois taps for x^8 + x^6 + x^5 + x^4 + 1, maximal length
  localparam logic [LFSR_W-1:0] LFSR_TAPS = 8'hB8;

endpackage

`default_nettype wire
